/* hw/cpu_pkg.sv */
package cpu_pkg;

    localparam int WORD_W      = 16;
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_INDEX_W = 4;
    localparam int BTB_TAG_W   = WORD_W - BTB_INDEX_W;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [1:0]        reg_idx_t;

    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_JAL   = 4'd10,
        OP_RTYPE = 4'd15
    } opcode_t;

    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } funct_t;

    typedef struct packed {
        opcode_t    opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        funct_t     funct;
    } instr_r_t;

    typedef struct packed {
        opcode_t    opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        logic [7:0] imm;
    } instr_i_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [11:0] target;
    } instr_j_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_j_t j;
    } instr_t;

    // Unused opcode 2, decodes to a no-op
    localparam word_t    NOP_WORD = 16'h2000;
    localparam reg_idx_t LINK_REG = 2'd2;

    // Forwarding selects for the execute operands
    localparam logic [1:0] FWD_NONE = 2'd0;
    localparam logic [1:0] FWD_MEM  = 2'd1;
    localparam logic [1:0] FWD_WB   = 2'd2;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_LHI,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        WB_RD,
        WB_RT,
        WB_LINK,
        WB_NONE
    } wb_dest_t;

    typedef struct packed {
        alu_op_t  alu_op;
        logic     alu_src_imm;
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
        logic     mem_to_reg;
        logic     pc_to_reg;
        wb_dest_t wb_dest;
        logic     is_branch;
        logic     is_jump;
        logic     wwd;
        logic     halt;
    } ctrl_t;

    typedef struct packed {
        logic     valid;
        word_t    pc_next;
        ctrl_t    ctrl;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t dest;
        word_t    op_a;
        word_t    op_b;
        word_t    imm;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        reg_idx_t dest;
        word_t    alu_out;
        word_t    store_data;
        word_t    pc_next;
        word_t    wwd_val;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        reg_idx_t dest;
        word_t    result;
        word_t    wwd_val;
    } mem_wb_t;

endpackage

/* hw/control_unit.sv */
module control_unit
    import cpu_pkg::*;
(
    input  instr_t instr,
    output ctrl_t  ctrl,
    output logic   illegal
);

    always_comb begin
        ctrl         = '0;
        ctrl.alu_op  = ALU_PASS_B;
        ctrl.wb_dest = WB_NONE;
        illegal      = 1'b0;

        case (instr.r.opcode)
            OP_RTYPE: begin
                ctrl.wb_dest   = WB_RD;
                ctrl.reg_write = 1'b1;
                case (instr.r.funct)
                    FN_ADD: ctrl.alu_op = ALU_ADD;
                    FN_SUB: ctrl.alu_op = ALU_SUB;
                    FN_AND: ctrl.alu_op = ALU_AND;
                    FN_ORR: ctrl.alu_op = ALU_OR;
                    default: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.wb_dest   = WB_NONE;
                        ctrl.wwd       = (instr.r.funct == FN_WWD);
                        ctrl.halt      = (instr.r.funct == FN_HLT);
                        illegal        = !(ctrl.wwd || ctrl.halt);
                    end
                endcase
            end
            OP_ADI, OP_ORI, OP_LHI, OP_LWD: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.wb_dest     = WB_RT;
                ctrl.mem_read    = (instr.i.opcode == OP_LWD);
                ctrl.mem_to_reg  = (instr.i.opcode == OP_LWD);
                case (instr.i.opcode)
                    OP_ORI:  ctrl.alu_op = ALU_OR;
                    OP_LHI:  ctrl.alu_op = ALU_LHI;
                    default: ctrl.alu_op = ALU_ADD;
                endcase
            end
            OP_SWD: begin
                ctrl.alu_op      = ALU_ADD;
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            OP_BNE, OP_BEQ: ctrl.is_branch = 1'b1;
            OP_JMP:         ctrl.is_jump   = 1'b1;
            OP_JAL: begin
                ctrl.is_jump   = 1'b1;
                ctrl.pc_to_reg = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_dest   = WB_LINK;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

/* hw/register_file.sv */
module register_file
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  reg_idx_t rs,
    input  reg_idx_t rt,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data,
    output word_t    rs_data,
    output word_t    rt_data
);

    word_t regs [4];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            regs <= '{default: '0};
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Write-through so decode sees the value being written back
    assign rs_data = (wr_en && wr_idx == rs) ? wr_data : regs[rs];
    assign rt_data = (wr_en && wr_idx == rt) ? wr_data : regs[rt];

    assert property (@(posedge clk) disable iff (reset_n) wr_en |-> !$isunknown(wr_data));

endmodule

/* hw/hazard_unit.sv */
module hazard_unit
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  reg_idx_t   id_rs,
    input  reg_idx_t   id_rt,
    input  logic       id_uses_rs,
    input  logic       id_uses_rt,
    input  logic       id_is_branch,
    input  id_ex_t     id_ex,
    input  ex_mem_t    ex_mem,
    input  mem_wb_t    mem_wb,
    output logic       stall,
    output logic [1:0] forward_a,
    output logic [1:0] forward_b
);

    logic ex_hit;
    logic mem_load_hit;
    logic mem_fwd_ok;
    logic wb_fwd_ok;

    // Decode reads a register that the instruction in execute writes
    assign ex_hit = id_ex.valid && id_ex.ctrl.reg_write &&
        ((id_uses_rs && id_ex.dest == id_rs) || (id_uses_rt && id_ex.dest == id_rt));

    assign mem_load_hit = ex_mem.valid && ex_mem.ctrl.mem_read &&
        ((id_uses_rs && ex_mem.dest == id_rs) || (id_uses_rt && ex_mem.dest == id_rt));

    // Branches compare in decode, so they wait longer than ALU users
    assign stall = (ex_hit && id_ex.ctrl.mem_read) ||
                   (id_is_branch && (ex_hit || mem_load_hit));

    assign mem_fwd_ok = ex_mem.valid && ex_mem.ctrl.reg_write;
    assign wb_fwd_ok  = mem_wb.valid && mem_wb.ctrl.reg_write;

    always_comb begin
        forward_a = FWD_NONE;
        forward_b = FWD_NONE;
        if (mem_fwd_ok && ex_mem.dest == id_ex.rs) begin
            forward_a = FWD_MEM;
        end else if (wb_fwd_ok && mem_wb.dest == id_ex.rs) begin
            forward_a = FWD_WB;
        end
        if (mem_fwd_ok && ex_mem.dest == id_ex.rt) begin
            forward_b = FWD_MEM;
        end else if (wb_fwd_ok && mem_wb.dest == id_ex.rt) begin
            forward_b = FWD_WB;
        end
    end

    assert property (@(posedge clk) reset_n |=> !stall);

endmodule

/* hw/branch_predictor.sv */
module branch_predictor
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  word_t fetch_pc,
    output word_t pred_pc,
    input  logic  upd_valid,
    input  logic  upd_taken,
    input  word_t upd_pc,
    input  word_t upd_target
);

    logic [BTB_ENTRIES-1:0] valid_q;
    logic [BTB_TAG_W-1:0]   tag_q [BTB_ENTRIES];
    word_t                  target_q [BTB_ENTRIES];

    logic [BTB_INDEX_W-1:0] fetch_idx;
    logic [BTB_INDEX_W-1:0] upd_idx;
    logic [BTB_TAG_W-1:0]   fetch_tag;
    logic [BTB_TAG_W-1:0]   upd_tag;
    logic                   hit;

    assign fetch_idx = fetch_pc[BTB_INDEX_W-1:0];
    assign fetch_tag = fetch_pc[WORD_W-1:BTB_INDEX_W];
    assign upd_idx   = upd_pc[BTB_INDEX_W-1:0];
    assign upd_tag   = upd_pc[WORD_W-1:BTB_INDEX_W];

    assign hit     = valid_q[fetch_idx] && tag_q[fetch_idx] == fetch_tag;
    assign pred_pc = hit ? target_q[fetch_idx] : fetch_pc + 16'd1;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            valid_q <= '0;
        end else if (upd_valid) begin
            if (upd_taken) begin
                valid_q[upd_idx]  <= 1'b1;
                tag_q[upd_idx]    <= upd_tag;
                target_q[upd_idx] <= upd_target;
            end else if (tag_q[upd_idx] == upd_tag) begin
                // Falls through now, drop the stale target
                valid_q[upd_idx] <= 1'b0;
            end
        end
    end

endmodule

/* hw/cpu.sv */
module cpu
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    output logic       read_m1,
    output word_t      address1,
    input  word_t      data1,
    output logic       read_m2,
    output logic       write_m2,
    output word_t      address2,
    inout  wire word_t data2,
    output word_t      num_inst,
    output word_t      output_port,
    output logic       is_halted
);

    typedef struct packed {
        logic   valid;
        word_t  pc;
        word_t  pred_pc;
        instr_t instr;
    } if_id_t;

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    word_t      pc;
    word_t      fetch_pred;
    logic       halt_pending;
    logic       halted_q;
    ctrl_t      id_ctrl;
    logic       id_illegal;
    word_t      rs_data;
    word_t      rt_data;
    word_t      cmp_a;
    word_t      cmp_b;
    word_t      id_imm;
    word_t      id_pc_plus1;
    word_t      id_next_pc;
    reg_idx_t   id_dest;
    logic       id_uses_rs;
    logic       id_uses_rt;
    logic       br_taken;
    logic       mispredict;
    logic       fetch_stop;
    logic       stall;
    logic [1:0] forward_a;
    logic [1:0] forward_b;
    word_t      mem_value;
    word_t      ex_a;
    word_t      ex_b;
    word_t      alu_b;
    word_t      alu_out;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch

    assign address1   = pc;
    assign fetch_stop = halt_pending || (if_id.valid && id_ctrl.halt);
    assign read_m1    = !fetch_stop;

    branch_predictor i_branch_predictor (
        .clk       (clk),
        .reset_n   (reset_n),
        .fetch_pc  (pc),
        .pred_pc   (fetch_pred),
        .upd_valid (if_id.valid && !stall),
        .upd_taken (id_ctrl.is_jump || br_taken),
        .upd_pc    (if_id.pc),
        .upd_target(id_next_pc)
    );

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc           <= '0;
            if_id.valid  <= 1'b0;
            if_id.instr  <= NOP_WORD;
            halt_pending <= 1'b0;
        end else if (stall) begin
            // Hold PC and the decode instruction
        end else if (fetch_stop) begin
            if_id.valid  <= 1'b0;
            if_id.instr  <= NOP_WORD;
            halt_pending <= 1'b1;
        end else if (mispredict) begin
            pc          <= id_next_pc;
            if_id.valid <= 1'b0;
            if_id.instr <= NOP_WORD;
        end else begin
            pc            <= fetch_pred;
            if_id.valid   <= 1'b1;
            if_id.pc      <= pc;
            if_id.pred_pc <= fetch_pred;
            if_id.instr   <= data1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Decode, branches and jumps resolve here

    control_unit i_control_unit (
        .instr  (if_id.instr),
        .ctrl   (id_ctrl),
        .illegal(id_illegal)
    );

    register_file i_register_file (
        .clk    (clk),
        .reset_n(reset_n),
        .rs     (if_id.instr.r.rs),
        .rt     (if_id.instr.r.rt),
        .wr_en  (mem_wb.valid && mem_wb.ctrl.reg_write),
        .wr_idx (mem_wb.dest),
        .wr_data(mem_wb.result),
        .rs_data(rs_data),
        .rt_data(rt_data)
    );

    assign id_uses_rs = if_id.valid &&
        !(id_ctrl.halt || id_ctrl.is_jump || id_ctrl.alu_op == ALU_LHI);
    assign id_uses_rt = if_id.valid && (id_ctrl.is_branch || id_ctrl.mem_write ||
        (if_id.instr.r.opcode == OP_RTYPE && !id_ctrl.wwd && !id_ctrl.halt));

    hazard_unit i_hazard_unit (
        .clk         (clk),
        .reset_n     (reset_n),
        .id_rs       (if_id.instr.r.rs),
        .id_rt       (if_id.instr.r.rt),
        .id_uses_rs  (id_uses_rs),
        .id_uses_rt  (id_uses_rt),
        .id_is_branch(if_id.valid && id_ctrl.is_branch),
        .id_ex       (id_ex),
        .ex_mem      (ex_mem),
        .mem_wb      (mem_wb),
        .stall       (stall),
        .forward_a   (forward_a),
        .forward_b   (forward_b)
    );

    // Memory-stage result reaches the comparator, loads there stall instead
    assign mem_value = ex_mem.ctrl.pc_to_reg ? ex_mem.pc_next : ex_mem.alu_out;
    assign cmp_a = (ex_mem.valid && ex_mem.ctrl.reg_write && ex_mem.dest == if_id.instr.r.rs) ?
        mem_value : rs_data;
    assign cmp_b = (ex_mem.valid && ex_mem.ctrl.reg_write && ex_mem.dest == if_id.instr.r.rt) ?
        mem_value : rt_data;

    assign id_imm      = {{8{if_id.instr.i.imm[7]}}, if_id.instr.i.imm};
    assign id_pc_plus1 = if_id.pc + 16'd1;
    assign br_taken    = id_ctrl.is_branch &&
        ((if_id.instr.i.opcode == OP_BEQ) == (cmp_a == cmp_b));

    always_comb begin
        if (id_ctrl.is_jump) begin
            id_next_pc = {if_id.pc[15:12], if_id.instr.j.target};
        end else if (br_taken) begin
            id_next_pc = id_pc_plus1 + id_imm;
        end else begin
            id_next_pc = id_pc_plus1;
        end
        case (id_ctrl.wb_dest)
            WB_RD:   id_dest = if_id.instr.r.rd;
            WB_RT:   id_dest = if_id.instr.i.rt;
            WB_LINK: id_dest = LINK_REG;
            default: id_dest = '0;
        endcase
    end

    assign mispredict = if_id.valid && id_next_pc != if_id.pred_pc;

    ////////////////////////////////////////////////////////////////////////////
    // Execute, memory and write-back

    always_comb begin
        case (forward_a)
            FWD_MEM: ex_a = mem_value;
            FWD_WB:  ex_a = mem_wb.result;
            default: ex_a = id_ex.op_a;
        endcase
        case (forward_b)
            FWD_MEM: ex_b = mem_value;
            FWD_WB:  ex_b = mem_wb.result;
            default: ex_b = id_ex.op_b;
        endcase
    end

    assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : ex_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_ADD: alu_out = ex_a + alu_b;
            ALU_SUB: alu_out = ex_a - alu_b;
            ALU_AND: alu_out = ex_a & alu_b;
            ALU_OR:  alu_out = ex_a | alu_b;
            ALU_LHI: alu_out = {alu_b[7:0], 8'h00};
            default: alu_out = alu_b;
        endcase
    end

    assign read_m2  = ex_mem.valid && ex_mem.ctrl.mem_read;
    assign write_m2 = ex_mem.valid && ex_mem.ctrl.mem_write;
    assign address2 = ex_mem.alu_out;
    assign data2    = write_m2 ? ex_mem.store_data : 'z;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            id_ex.valid  <= 1'b0;
            ex_mem.valid <= 1'b0;
            mem_wb.valid <= 1'b0;
        end else begin
            id_ex.valid   <= if_id.valid && !stall;
            id_ex.pc_next <= id_pc_plus1;
            id_ex.ctrl    <= id_ctrl;
            id_ex.rs      <= if_id.instr.r.rs;
            id_ex.rt      <= if_id.instr.r.rt;
            id_ex.dest    <= id_dest;
            id_ex.op_a    <= rs_data;
            id_ex.op_b    <= rt_data;
            id_ex.imm     <= id_imm;

            ex_mem.valid      <= id_ex.valid;
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.dest       <= id_ex.dest;
            ex_mem.alu_out    <= alu_out;
            ex_mem.store_data <= ex_b;
            ex_mem.pc_next    <= id_ex.pc_next;
            ex_mem.wwd_val    <= ex_a;

            mem_wb.valid   <= ex_mem.valid;
            mem_wb.ctrl    <= ex_mem.ctrl;
            mem_wb.dest    <= ex_mem.dest;
            mem_wb.result  <= ex_mem.ctrl.mem_to_reg ? data2 : mem_value;
            mem_wb.wwd_val <= ex_mem.wwd_val;
        end
    end

    // Retire
    always_ff @(posedge clk) begin
        if (reset_n) begin
            num_inst <= '0;
            halted_q <= 1'b0;
        end else if (mem_wb.valid && !halted_q) begin
            num_inst <= num_inst + 16'd1;
            halted_q <= mem_wb.ctrl.halt;
        end
    end

    assign is_halted   = halted_q || (mem_wb.valid && mem_wb.ctrl.halt);
    assign output_port = (mem_wb.valid && mem_wb.ctrl.wwd) ? mem_wb.wwd_val : '0;

    assert property (@(posedge clk) disable iff (reset_n) !(read_m2 && write_m2));
    assert property (@(posedge clk) disable iff (reset_n) if_id.valid |-> !id_illegal);

endmodule

/* tests/cpu_tb.sv */
module cpu_tb
    import cpu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PROGRAMS     = 8;
    localparam int BODY_LEN         = 35;
    localparam int PROG_WORDS       = BODY_LEN + 9;
    localparam int MODEL_STEP_LIMIT = 2000;
    localparam int TIMEOUT_CYCLES   = 8 * (40 * 4 + 30);

    typedef struct packed {
        logic  is_wwd;
        word_t value;
    } retire_t;

    logic        clk;
    logic        reset_n;
    logic        read_m1;
    word_t       address1;
    word_t       data1;
    logic        read_m2;
    logic        write_m2;
    word_t       address2;
    wire  [15:0] data2;
    word_t       num_inst;
    word_t       output_port;
    logic        is_halted;

    word_t       mem [65536];
    word_t       model_mem [65536];
    retire_t     expected [$];
    logic [31:0] seed;
    int          error_count;
    int          retired_checked;
    int          cycle_count = 0;

    cpu i_cpu (
        .clk        (clk),
        .reset_n    (reset_n),
        .read_m1    (read_m1),
        .address1   (address1),
        .data1      (data1),
        .read_m2    (read_m2),
        .write_m2   (write_m2),
        .address2   (address2),
        .data2      (data2),
        .num_inst   (num_inst),
        .output_port(output_port),
        .is_halted  (is_halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory model with combinational reads and writes on the rising edge

    assign data1 = mem[address1];
    assign data2 = read_m2 ? mem[address2] : 'z;

    always @(posedge clk) begin
        if (write_m2) begin
            mem[address2] <= data2;
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Programs: %0d, retirements checked: %0d, errors: %0d",
                     NUM_PROGRAMS, retired_checked, error_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    function automatic int unsigned pick(input int unsigned n);
        seed = seed * 32'd1664525 + 32'd1013904223;
        return (seed >> 8) % n;
    endfunction

    function automatic word_t sext8(input logic [7:0] v);
        return {{8{v[7]}}, v};
    endfunction

    function automatic word_t fill_word(input word_t addr);
        return {addr[7:0], addr[15:8]} ^ (addr * 16'd3) ^ 16'h5ac3;
    endfunction

    function automatic word_t enc_r(input logic [5:0] funct, input reg_idx_t rs,
                                    input reg_idx_t rt, input reg_idx_t rd);
        return {OP_RTYPE, rs, rt, rd, funct};
    endfunction

    function automatic word_t enc_i(input logic [3:0] op, input reg_idx_t rs,
                                    input reg_idx_t rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_j(input logic [3:0] op, input logic [11:0] target);
        return {op, target};
    endfunction

    task automatic report_error(input string msg);
        error_count++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Program generator

    task automatic build_program();
        word_t       prog [PROG_WORDS];
        int          ctl [BODY_LEN];
        logic        no_target [PROG_WORDS];
        int          i;
        int          tgt;
        int          span;
        int unsigned k;
        int unsigned sel;
        reg_idx_t    ra;
        reg_idx_t    rb;
        reg_idx_t    rc;
        logic [7:0]  imm;
        logic [5:0]  fn;

        ctl       = '{default: 0};
        no_target = '{default: 1'b0};
        i = 0;
        while (i < BODY_LEN) begin
            k   = pick(100);
            ra  = 2'(pick(4));
            rb  = 2'(pick(4));
            rc  = 2'(pick(4));
            imm = 8'(pick(256));
            sel = pick(2);
            fn  = 6'(pick(4));
            if (k < 30) begin
                prog[i] = enc_r(fn, ra, rb, rc);
            end else if (k < 38) begin
                prog[i] = enc_r(FN_WWD, ra, rb, rc);
            end else if (k < 50) begin
                prog[i] = enc_i(sel ? OP_ORI : OP_ADI, ra, rb, imm);
            end else if (k < 56) begin
                prog[i] = enc_i(OP_LHI, ra, rb, imm);
            end else if (k < 64) begin
                prog[i] = enc_i(OP_LWD, ra, rb, imm);
            end else if (k < 72 && i + 1 < BODY_LEN) begin
                // Base register points into the data region
                prog[i]       = enc_i(OP_LHI, ra, rb, 8'h80);
                prog[i+1]     = enc_i(OP_SWD, rb, rc, imm);
                no_target[i+1] = 1'b1;
                i++;
            end else if (k < 88) begin
                prog[i] = enc_i(sel ? OP_BEQ : OP_BNE, ra, rb, 8'h00);
                ctl[i]  = 1;
            end else begin
                prog[i] = enc_j(sel ? OP_JAL : OP_JMP, 12'h000);
                ctl[i]  = 2;
            end
            i++;
        end

        // Forward targets only and never onto a store that needs its LHI
        for (i = 0; i < BODY_LEN; i++) begin
            if (ctl[i] != 0) begin
                span = BODY_LEN - i - 1;
                if (span > 126) begin
                    span = 126;
                end
                tgt = i + 1 + int'(pick(span + 1));
                if (no_target[tgt]) begin
                    tgt++;
                end
                if (ctl[i] == 1) begin
                    prog[i][7:0] = 8'(tgt - i - 1);
                end else begin
                    prog[i][11:0] = 12'(tgt);
                end
            end
        end

        for (i = 0; i < 4; i++) begin
            prog[BODY_LEN+i] = enc_r(FN_WWD, 2'(i), 2'd0, 2'd0);
        end
        prog[BODY_LEN+4] = enc_r(FN_HLT, 2'd0, 2'd0, 2'd0);
        for (i = BODY_LEN + 5; i < PROG_WORDS; i++) begin
            prog[i] = word_t'(pick(65536));
        end

        for (int a = 0; a < 65536; a++) begin
            mem[a] = fill_word(word_t'(a));
        end
        for (i = 0; i < PROG_WORDS; i++) begin
            mem[i] = prog[i];
        end
        for (int a = 0; a < 65536; a++) begin
            model_mem[a] = mem[a];
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Instruction-set reference model

    task automatic run_model();
        word_t   regs [4];
        word_t   pc;
        word_t   next_pc;
        word_t   w;
        word_t   a;
        word_t   b;
        int      steps;
        logic    done;
        retire_t rec;

        regs  = '{default: '0};
        pc    = '0;
        steps = 0;
        done  = 1'b0;
        expected.delete();
        while (!done && steps < MODEL_STEP_LIMIT) begin
            w          = model_mem[pc];
            a          = regs[w[11:10]];
            b          = regs[w[9:8]];
            next_pc    = pc + 16'd1;
            rec.is_wwd = 1'b0;
            rec.value  = '0;
            steps++;
            case (w[15:12])
                OP_RTYPE: begin
                    case (w[5:0])
                        FN_ADD: regs[w[7:6]] = a + b;
                        FN_SUB: regs[w[7:6]] = a - b;
                        FN_AND: regs[w[7:6]] = a & b;
                        FN_ORR: regs[w[7:6]] = a | b;
                        FN_WWD: begin
                            rec.is_wwd = 1'b1;
                            rec.value  = a;
                        end
                        FN_HLT: done = 1'b1;
                        default: ;
                    endcase
                end
                OP_ADI: regs[w[9:8]] = a + sext8(w[7:0]);
                OP_ORI: regs[w[9:8]] = a | sext8(w[7:0]);
                OP_LHI: regs[w[9:8]] = {w[7:0], 8'h00};
                OP_LWD: regs[w[9:8]] = model_mem[a + sext8(w[7:0])];
                OP_SWD: model_mem[a + sext8(w[7:0])] = b;
                OP_BNE: begin
                    if (a != b) begin
                        next_pc = pc + 16'd1 + sext8(w[7:0]);
                    end
                end
                OP_BEQ: begin
                    if (a == b) begin
                        next_pc = pc + 16'd1 + sext8(w[7:0]);
                    end
                end
                OP_JMP: next_pc = {pc[15:12], w[11:0]};
                OP_JAL: begin
                    regs[2] = pc + 16'd1;
                    next_pc = {pc[15:12], w[11:0]};
                end
                default: ;
            endcase
            expected.push_back(rec);
            pc = next_pc;
        end
        if (!done) begin
            error_count++;
            $display("The reference model did not reach HLT within %0d steps", MODEL_STEP_LIMIT);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One program from reset to halt

    task automatic run_program(input int p);
        word_t   prev_cnt;
        word_t   prev_port;
        word_t   cnt_now;
        word_t   port_now;
        logic    halted_now;
        int      idx;
        int      exp_count;
        retire_t rec;

        @(posedge clk);
        #1;
        reset_n = 1'b1;
        build_program();
        run_model();
        exp_count = expected.size();
        repeat (5) @(posedge clk);
        #1;
        reset_n = 1'b0;

        @(negedge clk);
        if (num_inst !== '0 || is_halted !== 1'b0 || output_port !== '0 ||
            read_m2 !== 1'b0 || write_m2 !== 1'b0) begin
            report_error($sformatf("program %0d: outputs not cleared after reset", p));
        end

        prev_cnt  = num_inst;
        prev_port = output_port;
        cnt_now   = num_inst;
        idx       = 0;
        while (cnt_now < exp_count) begin
            @(negedge clk);
            cnt_now    = num_inst;
            port_now   = output_port;
            halted_now = is_halted;
            // Port value from the cycle before the count moved
            if (cnt_now == prev_cnt + 16'd1) begin
                rec = expected[idx];
                if (rec.is_wwd && prev_port !== rec.value) begin
                    report_error($sformatf("program %0d, retire %0d: output_port %h, expected %h",
                                           p, idx, prev_port, rec.value));
                end
                if (!rec.is_wwd && prev_port !== '0) begin
                    report_error($sformatf("program %0d, retire %0d: output_port %h, expected 0",
                                           p, idx, prev_port));
                end
                idx++;
                retired_checked++;
            end else if (cnt_now != prev_cnt) begin
                report_error($sformatf("program %0d: num_inst went from %0d to %0d",
                                       p, prev_cnt, cnt_now));
            end else if (prev_port !== '0) begin
                report_error($sformatf("program %0d: output_port %h with nothing retiring",
                                       p, prev_port));
            end
            if (halted_now && cnt_now + 1 < exp_count) begin
                report_error($sformatf("program %0d: is_halted high at count %0d of %0d",
                                       p, cnt_now, exp_count));
            end
            prev_cnt  = cnt_now;
            prev_port = port_now;
        end

        if (cnt_now != exp_count || halted_now !== 1'b1) begin
            report_error($sformatf("program %0d: count %0d halted %b, expected %0d halted 1",
                                   p, cnt_now, halted_now, exp_count));
        end
        repeat (10) begin
            @(negedge clk);
            if (num_inst !== exp_count || is_halted !== 1'b1) begin
                report_error($sformatf("program %0d: after halt count %0d halted %b",
                                       p, num_inst, is_halted));
            end
            // Fetch stays off once halted
            if (read_m1 !== 1'b0) begin
                report_error($sformatf("program %0d: read_m1 %b after halt, expected 0",
                                       p, read_m1));
            end
        end

        // Data region against the model
        for (int a = 16'h7f80; a <= 16'h807f; a++) begin
            if (mem[a] !== model_mem[a]) begin
                report_error($sformatf("program %0d: mem[%h] = %h, expected %h",
                                       p, a[15:0], mem[a], model_mem[a]));
            end
        end
    endtask

    initial begin
        seed            = 32'h8431;
        reset_n         = 1'b1;
        error_count     = 0;
        retired_checked = 0;
        for (int a = 0; a < 65536; a++) begin
            mem[a] = fill_word(word_t'(a));
        end

        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            run_program(p);
        end

        $display("Programs: %0d, retirements checked: %0d, errors: %0d",
                 NUM_PROGRAMS, retired_checked, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* files.f */
hw/cpu_pkg.sv
hw/control_unit.sv
hw/register_file.sv
hw/hazard_unit.sv
hw/branch_predictor.sv
hw/cpu.sv
tests/cpu_tb.sv

/* Bender.yml */
package:
  name: cpu

sources:
  - hw/cpu_pkg.sv
  - hw/control_unit.sv
  - hw/register_file.sv
  - hw/hazard_unit.sv
  - hw/branch_predictor.sv
  - hw/cpu.sv
  - target: test
    files:
      - tests/cpu_tb.sv
